//--- include/reasm_defs.svh
`ifndef REASM_DEFS_SVH
`define REASM_DEFS_SVH

// Flow table depth
`define REASM_FLOWS 4

// Shared pool of buffered out-of-order packets
`define REASM_NODES 8

// Descriptor field widths
`define REASM_SEQ_W 32
`define REASM_LEN_W 16
`define REASM_PKTID_W 8

`endif

//--- src/reasm_pkg.sv
`include "reasm_defs.svh"

package reasm_pkg;

    typedef logic [$clog2(`REASM_FLOWS)-1:0] flow_id_t;
    typedef logic [$clog2(`REASM_NODES)-1:0] node_ptr_t;
    typedef logic [`REASM_SEQ_W-1:0]         seq_t;
    typedef logic [`REASM_LEN_W-1:0]         len_t;
    typedef logic [`REASM_PKTID_W-1:0]       pkt_id_t;

    // Arriving packet descriptor
    typedef struct packed {
        flow_id_t flow;
        pkt_id_t  pkt_id;
        seq_t     seq;
        len_t     len;
        logic     fin;
    } pkt_desc_t;

    // Per-flow state, head is meaningful only with has_list set
    typedef struct packed {
        logic      valid;
        seq_t      exp_seq;
        logic      has_list;
        node_ptr_t head;
    } flow_entry_t;

    typedef struct packed {
        pkt_id_t   pkt_id;
        seq_t      seq;
        len_t      len;
        node_ptr_t next;
        logic      last;
    } list_node_t;

    typedef enum logic [1:0] {
        IN_ORDER,
        REORDERED,
        FORWARD,
        DROP
    } verdict_t;

    typedef struct packed {
        flow_id_t flow;
        pkt_id_t  pkt_id;
        verdict_t verdict;
    } release_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_ENTRY,
        CLASSIFY,
        DRAIN,
        INSERT,
        WRITE_BACK
    } ctrl_state_t;

endpackage

//--- src/flow_table.sv
`include "reasm_defs.svh"

module flow_table (
    input  logic                   clk,
    input  logic                   rst,
    input  reasm_pkg::flow_id_t    rd_flow,
    output reasm_pkg::flow_entry_t rd_entry,
    input  logic                   wr_en,
    input  reasm_pkg::flow_id_t    wr_flow,
    input  reasm_pkg::flow_entry_t wr_entry
);

    reasm_pkg::flow_entry_t entries [`REASM_FLOWS];

    // Only the valid bits matter after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REASM_FLOWS; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (wr_en) begin
            entries[wr_flow] <= wr_entry;
        end
    end

    // Registered read, entry shows up one cycle after rd_flow
    always_ff @(posedge clk) begin
        rd_entry <= entries[rd_flow];
    end

endmodule

//--- src/ooo_list.sv
`include "reasm_defs.svh"

module ooo_list (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ins_start,
    input  reasm_pkg::list_node_t ins_node,
    input  reasm_pkg::node_ptr_t  ins_head,
    input  logic                  ins_has_list,
    output logic                  ins_done,
    output logic                  ins_discard,
    output reasm_pkg::node_ptr_t  new_head,
    input  logic                  pop_start,
    input  reasm_pkg::node_ptr_t  pop_head,
    output reasm_pkg::list_node_t pop_node,
    output logic                  pop_valid
);

    localparam int CNT_W = $clog2(`REASM_NODES + 1);

    reasm_pkg::list_node_t node_mem [`REASM_NODES];
    reasm_pkg::node_ptr_t  free_stk [`REASM_NODES];
    logic [CNT_W-1:0]      free_cnt;

    // Walk state for a sorted insert
    logic                  walking;
    logic                  has_prev;
    reasm_pkg::node_ptr_t  cur;
    reasm_pkg::node_ptr_t  prev;
    reasm_pkg::list_node_t node_q;

    reasm_pkg::list_node_t cur_node;
    reasm_pkg::node_ptr_t  alloc_ptr;

    assign cur_node  = node_mem[cur];
    assign alloc_ptr = free_stk[reasm_pkg::node_ptr_t'(free_cnt - 1'b1)];

    always_ff @(posedge clk) begin
        if (rst) begin
            walking     <= 1'b0;
            ins_done    <= 1'b0;
            ins_discard <= 1'b0;
            pop_valid   <= 1'b0;
            free_cnt    <= CNT_W'(`REASM_NODES);
            for (int i = 0; i < `REASM_NODES; i++) begin
                free_stk[i] <= reasm_pkg::node_ptr_t'(i);
            end
        end else begin
            ins_done    <= 1'b0;
            ins_discard <= 1'b0;
            pop_valid   <= pop_start;

            if (ins_start) begin
                node_q   <= ins_node;
                new_head <= ins_head;
                if (free_cnt == '0) begin
                    // Pool exhausted
                    ins_done    <= 1'b1;
                    ins_discard <= 1'b1;
                end else if (!ins_has_list) begin
                    // Single-node list
                    node_mem[alloc_ptr]      <= ins_node;
                    node_mem[alloc_ptr].last <= 1'b1;
                    free_cnt                 <= free_cnt - 1'b1;
                    new_head                 <= alloc_ptr;
                    ins_done                 <= 1'b1;
                end else begin
                    walking  <= 1'b1;
                    cur      <= ins_head;
                    has_prev <= 1'b0;
                end
            end else if (walking) begin
                if (cur_node.seq == node_q.seq) begin
                    // Already buffered
                    walking     <= 1'b0;
                    ins_done    <= 1'b1;
                    ins_discard <= 1'b1;
                end else if (cur_node.seq > node_q.seq) begin
                    // Link in front of cur
                    walking                  <= 1'b0;
                    ins_done                 <= 1'b1;
                    free_cnt                 <= free_cnt - 1'b1;
                    node_mem[alloc_ptr]      <= node_q;
                    node_mem[alloc_ptr].next <= cur;
                    node_mem[alloc_ptr].last <= 1'b0;
                    if (has_prev) begin
                        node_mem[prev].next <= alloc_ptr;
                    end else begin
                        new_head <= alloc_ptr;
                    end
                end else if (cur_node.last) begin
                    // Largest seq so far, append at the tail
                    walking                  <= 1'b0;
                    ins_done                 <= 1'b1;
                    free_cnt                 <= free_cnt - 1'b1;
                    node_mem[alloc_ptr]      <= node_q;
                    node_mem[alloc_ptr].last <= 1'b1;
                    node_mem[cur].next       <= alloc_ptr;
                    node_mem[cur].last       <= 1'b0;
                end else begin
                    prev     <= cur;
                    has_prev <= 1'b1;
                    cur      <= cur_node.next;
                end
            end

            // Popped head goes back on the free stack
            if (pop_start) begin
                free_stk[reasm_pkg::node_ptr_t'(free_cnt)] <= pop_head;
                free_cnt                                   <= free_cnt + 1'b1;
            end
        end
    end

    // Head node is read every cycle, so the controller can check it before popping
    always_ff @(posedge clk) begin
        pop_node <= node_mem[pop_head];
    end

endmodule

//--- src/reasm_ctrl.sv
module reasm_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  reasm_pkg::pkt_desc_t   pkt,
    input  logic                   pkt_valid,
    output logic                   pkt_ready,
    output reasm_pkg::release_t    rel,
    output logic                   rel_valid,
    input  logic                   rel_hold,
    output reasm_pkg::flow_id_t    rd_flow,
    input  reasm_pkg::flow_entry_t rd_entry,
    output logic                   wr_en,
    output reasm_pkg::flow_id_t    wr_flow,
    output reasm_pkg::flow_entry_t wr_entry,
    output logic                   ins_start,
    output reasm_pkg::list_node_t  ins_node,
    output reasm_pkg::node_ptr_t   ins_head,
    output logic                   ins_has_list,
    input  logic                   ins_done,
    input  logic                   ins_discard,
    input  reasm_pkg::node_ptr_t   new_head,
    output logic                   pop_start,
    output reasm_pkg::node_ptr_t   pop_head,
    input  reasm_pkg::list_node_t  pop_node,
    input  logic                   pop_valid
);

    reasm_pkg::ctrl_state_t state;
    logic [1:0]             step;
    logic                   started;
    reasm_pkg::pkt_desc_t   desc_q;
    reasm_pkg::flow_entry_t ent_q;
    logic                   in_order;
    reasm_pkg::seq_t        end_seq;

    // No acceptance until the first cycle after reset
    assign pkt_ready = started && (state == reasm_pkg::IDLE) && pkt_valid && !rel_hold;

    assign rd_flow  = desc_q.flow;
    assign wr_en    = (state == reasm_pkg::WRITE_BACK);
    assign wr_flow  = desc_q.flow;
    assign wr_entry = ent_q;

    assign ins_head     = ent_q.head;
    assign ins_has_list = ent_q.has_list;

    always_comb begin
        ins_node        = '0;
        ins_node.pkt_id = desc_q.pkt_id;
        ins_node.seq    = desc_q.seq;
        ins_node.len    = desc_q.len;
    end

    // A closed or unknown flow is opened by whatever arrives
    assign in_order = !rd_entry.valid || (desc_q.seq == rd_entry.exp_seq);
    assign end_seq  = desc_q.seq + desc_q.len;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= reasm_pkg::IDLE;
            step      <= '0;
            started   <= 1'b0;
            rel_valid <= 1'b0;
            ins_start <= 1'b0;
            pop_start <= 1'b0;
        end else begin
            started   <= 1'b1;
            rel_valid <= 1'b0;
            ins_start <= 1'b0;
            pop_start <= 1'b0;

            case (state)
                reasm_pkg::IDLE: begin
                    if (pkt_ready) begin
                        desc_q <= pkt;
                        state  <= reasm_pkg::READ_ENTRY;
                    end
                end
                reasm_pkg::READ_ENTRY: begin
                    state <= reasm_pkg::CLASSIFY;
                end
                reasm_pkg::CLASSIFY: begin
                    ent_q <= rd_entry;
                    step  <= '0;
                    if (in_order) begin
                        if (!rel_hold) begin
                            rel_valid <= 1'b1;
                            rel.flow  <= desc_q.flow;
                            rel.pkt_id <= desc_q.pkt_id;
                            rel.verdict <= desc_q.fin ? reasm_pkg::FORWARD
                                                      : reasm_pkg::IN_ORDER;
                            if (desc_q.fin) begin
                                ent_q <= '0;
                                state <= reasm_pkg::WRITE_BACK;
                            end else begin
                                ent_q.valid    <= 1'b1;
                                ent_q.exp_seq  <= end_seq;
                                ent_q.has_list <= rd_entry.valid && rd_entry.has_list;
                                if (rd_entry.valid && rd_entry.has_list) begin
                                    pop_head <= rd_entry.head;
                                    state    <= reasm_pkg::DRAIN;
                                end else begin
                                    state <= reasm_pkg::WRITE_BACK;
                                end
                            end
                        end
                    end else if (desc_q.seq > rd_entry.exp_seq) begin
                        ins_start <= 1'b1;
                        state     <= reasm_pkg::INSERT;
                    end else if (!rel_hold) begin
                        // Overlap with data already passed on
                        rel_valid   <= 1'b1;
                        rel.flow    <= desc_q.flow;
                        rel.pkt_id  <= desc_q.pkt_id;
                        rel.verdict <= reasm_pkg::DROP;
                        state       <= reasm_pkg::WRITE_BACK;
                    end
                end
                reasm_pkg::DRAIN: begin
                    case (step)
                        2'd0: begin
                            // pop_node catches up with pop_head
                            step <= 2'd1;
                        end
                        2'd1: begin
                            if (pop_node.seq != ent_q.exp_seq) begin
                                state <= reasm_pkg::WRITE_BACK;
                            end else if (!rel_hold) begin
                                pop_start     <= 1'b1;
                                rel_valid     <= 1'b1;
                                rel.flow      <= desc_q.flow;
                                rel.pkt_id    <= pop_node.pkt_id;
                                rel.verdict   <= reasm_pkg::REORDERED;
                                ent_q.exp_seq <= pop_node.seq + pop_node.len;
                                step          <= 2'd2;
                            end
                        end
                        default: begin
                            if (pop_valid) begin
                                if (pop_node.last) begin
                                    ent_q.has_list <= 1'b0;
                                    state          <= reasm_pkg::WRITE_BACK;
                                end else begin
                                    ent_q.head <= pop_node.next;
                                    pop_head   <= pop_node.next;
                                    step       <= 2'd0;
                                end
                            end
                        end
                    endcase
                end
                reasm_pkg::INSERT: begin
                    if (step == 2'd0) begin
                        if (ins_done) begin
                            if (ins_discard) begin
                                step <= 2'd1;
                            end else begin
                                ent_q.head     <= new_head;
                                ent_q.has_list <= 1'b1;
                                state          <= reasm_pkg::WRITE_BACK;
                            end
                        end
                    end else if (!rel_hold) begin
                        // List full or duplicate seq
                        rel_valid   <= 1'b1;
                        rel.flow    <= desc_q.flow;
                        rel.pkt_id  <= desc_q.pkt_id;
                        rel.verdict <= reasm_pkg::DROP;
                        state       <= reasm_pkg::WRITE_BACK;
                    end
                end
                reasm_pkg::WRITE_BACK: begin
                    state <= reasm_pkg::IDLE;
                end
                default: begin
                    state <= reasm_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

//--- src/flow_reasm_top.sv
module flow_reasm_top (
    input  logic                 clk,
    input  logic                 rst,
    input  reasm_pkg::pkt_desc_t pkt,
    input  logic                 pkt_valid,
    output logic                 pkt_ready,
    output reasm_pkg::release_t  rel,
    output logic                 rel_valid,
    input  logic                 rel_hold
);

    // Flow table link
    reasm_pkg::flow_id_t    rd_flow;
    reasm_pkg::flow_entry_t rd_entry;
    logic                   wr_en;
    reasm_pkg::flow_id_t    wr_flow;
    reasm_pkg::flow_entry_t wr_entry;

    // List engine link
    logic                   ins_start;
    reasm_pkg::list_node_t  ins_node;
    reasm_pkg::node_ptr_t   ins_head;
    logic                   ins_has_list;
    logic                   ins_done;
    logic                   ins_discard;
    reasm_pkg::node_ptr_t   new_head;
    logic                   pop_start;
    reasm_pkg::node_ptr_t   pop_head;
    reasm_pkg::list_node_t  pop_node;
    logic                   pop_valid;

    reasm_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .pkt          (pkt),
        .pkt_valid    (pkt_valid),
        .pkt_ready    (pkt_ready),
        .rel          (rel),
        .rel_valid    (rel_valid),
        .rel_hold     (rel_hold),
        .rd_flow      (rd_flow),
        .rd_entry     (rd_entry),
        .wr_en        (wr_en),
        .wr_flow      (wr_flow),
        .wr_entry     (wr_entry),
        .ins_start    (ins_start),
        .ins_node     (ins_node),
        .ins_head     (ins_head),
        .ins_has_list (ins_has_list),
        .ins_done     (ins_done),
        .ins_discard  (ins_discard),
        .new_head     (new_head),
        .pop_start    (pop_start),
        .pop_head     (pop_head),
        .pop_node     (pop_node),
        .pop_valid    (pop_valid)
    );

    flow_table u_table (
        .clk      (clk),
        .rst      (rst),
        .rd_flow  (rd_flow),
        .rd_entry (rd_entry),
        .wr_en    (wr_en),
        .wr_flow  (wr_flow),
        .wr_entry (wr_entry)
    );

    ooo_list u_list (
        .clk          (clk),
        .rst          (rst),
        .ins_start    (ins_start),
        .ins_node     (ins_node),
        .ins_head     (ins_head),
        .ins_has_list (ins_has_list),
        .ins_done     (ins_done),
        .ins_discard  (ins_discard),
        .new_head     (new_head),
        .pop_start    (pop_start),
        .pop_head     (pop_head),
        .pop_node     (pop_node),
        .pop_valid    (pop_valid)
    );

endmodule

//--- dv/flow_reasm_checker.sv
module flow_reasm_checker (
    input logic clk,
    input logic rst,
    input logic pkt_valid,
    input logic pkt_ready,
    input logic rel_valid,
    input logic rel_hold
);

    // Failed properties so far, read back by the testbench
    int fail_cnt = 0;

    // Acceptance only answers a waiting descriptor
    ready_needs_valid: assert property (
        @(posedge clk) disable iff (rst) pkt_ready |-> pkt_valid
    ) else begin
        fail_cnt++;
        $error("pkt_ready rose without pkt_valid");
    end

    // Downstream almost-full blocks the following cycle
    hold_blocks_release: assert property (
        @(posedge clk) disable iff (rst) rel_hold |=> !rel_valid
    ) else begin
        fail_cnt++;
        $error("release issued in the cycle after rel_hold was high");
    end

    no_accept_in_reset: assert property (
        @(posedge clk) rst |-> !pkt_ready
    ) else begin
        fail_cnt++;
        $error("descriptor accepted while rst was high");
    end

    // rel_valid is cleared on the first reset edge
    no_release_in_reset: assert property (
        @(posedge clk) rst |=> !rel_valid
    ) else begin
        fail_cnt++;
        $error("release issued while rst was high");
    end

endmodule

//--- dv/tb_flow_reasm.sv
`include "reasm_defs.svh"

module tb_flow_reasm;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 200;

    logic                 clk       = 1'b0;
    logic                 rst       = 1'b1;
    reasm_pkg::pkt_desc_t pkt       = '0;
    logic                 pkt_valid = 1'b0;
    logic                 rel_hold  = 1'b0;
    logic                 pkt_ready;
    reasm_pkg::release_t  rel;
    logic                 rel_valid;
    logic                 hold_en   = 1'b0;

    // Reference model of flow state and buffered packets
    logic                 m_valid [`REASM_FLOWS];
    reasm_pkg::seq_t      m_exp [`REASM_FLOWS];
    reasm_pkg::pkt_desc_t held [$];
    reasm_pkg::release_t  exp_q [$];
    reasm_pkg::release_t  want;
    string                test_name;
    int                   errors = 0;
    int                   start_errors;
    int                   failed_tests = 0;
    int                   assert_fails = 0;

    flow_reasm_top dut (
        .clk       (clk),
        .rst       (rst),
        .pkt       (pkt),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .rel       (rel),
        .rel_valid (rel_valid),
        .rel_hold  (rel_hold)
    );

    bind flow_reasm_top flow_reasm_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .rel_valid (rel_valid),
        .rel_hold  (rel_hold)
    );

    always #4 clk = ~clk;

    // Downstream almost-full pulses
    always @(negedge clk) begin
        rel_hold = hold_en && ($urandom_range(0, 2) == 0);
    end

    always @(negedge clk) begin
        if (!rst && rel_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: test %s released packet %0d when none was due",
                         test_name, rel.pkt_id);
                errors++;
            end else begin
                want = exp_q.pop_front();
                check_rel: assert (rel == want) else begin
                    $display("FAIL %s: expected id %0d verdict %0d, actual id %0d verdict %0d",
                             test_name, want.pkt_id, want.verdict, rel.pkt_id, rel.verdict);
                    errors++;
                end
            end
        end
    end

    function automatic void expect_rel(input reasm_pkg::pkt_desc_t p, reasm_pkg::verdict_t v);
        exp_q.push_back('{flow: p.flow, pkt_id: p.pkt_id, verdict: v});
    endfunction

    // Lowest buffered seq of a flow or -1 when there is none
    function automatic int head_of(input reasm_pkg::flow_id_t f);
        int h = -1;
        foreach (held[i]) begin
            if (held[i].flow == f && (h < 0 || held[i].seq < held[h].seq)) h = i;
        end
        return h;
    endfunction

    function automatic void predict(input reasm_pkg::pkt_desc_t p);
        int h;
        if (!m_valid[p.flow] || p.seq == m_exp[p.flow]) begin
            expect_rel(p, p.fin ? reasm_pkg::FORWARD : reasm_pkg::IN_ORDER);
            h = m_valid[p.flow] ? head_of(p.flow) : -1;
            m_valid[p.flow] = !p.fin;
            m_exp[p.flow]   = p.seq + reasm_pkg::seq_t'(p.len);
            while (!p.fin && h >= 0 && held[h].seq == m_exp[p.flow]) begin
                expect_rel(held[h], reasm_pkg::REORDERED);
                m_exp[p.flow] = held[h].seq + reasm_pkg::seq_t'(held[h].len);
                held.delete(h);
                h = head_of(p.flow);
            end
        end else if (p.seq > m_exp[p.flow] && held.size() < `REASM_NODES) begin
            held.push_back(p);
        end else begin
            expect_rel(p, reasm_pkg::DROP);
        end
    endfunction

    // Offer one descriptor after a random gap and wait for acceptance
    task automatic send(input int f, input int id, input int s, input int l, input bit fin);
        repeat ($urandom_range(0, 3)) @(negedge clk);
        pkt.flow   = reasm_pkg::flow_id_t'(f);
        pkt.pkt_id = reasm_pkg::pkt_id_t'(id);
        pkt.seq    = reasm_pkg::seq_t'(s);
        pkt.len    = reasm_pkg::len_t'(l);
        pkt.fin    = fin;
        pkt_valid  = 1'b1;
        #1;
        while (!pkt_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        pkt_valid = 1'b0;
        predict(pkt);
    endtask

    // Fold in new failures of the bound checker
    task automatic count_assert_fails();
        errors      += dut.u_checker.fail_cnt - assert_fails;
        assert_fails = dut.u_checker.fail_cnt;
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        start_errors = errors;
    endtask

    task automatic finish_test();
        int cycles = 0;
        while (exp_q.size() != 0 && cycles < TEST_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: test %s timed out with %0d releases missing",
                     test_name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        count_assert_fails();
        if (errors != start_errors) failed_tests++;
        $display("test %-14s %s", test_name, (errors == start_errors) ? "passed" : "failed");
    endtask

    initial begin
        void'($urandom(32'ha04e_b1dd));
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        // A descriptor offered during reset must not be taken
        pkt_valid = 1'b1;
        repeat (16) @(negedge clk);
        pkt_valid = 1'b0;
        rst = 1'b0;

        start_test("new_flow");
        send(0, 1, 1000, 100, 0);
        send(0, 2, 1100, 100, 0);
        finish_test();

        // Arrivals out of seq order exercise the sorted insert
        start_test("fill_hole");
        send(1, 10, 0, 10, 0);
        send(1, 11, 30, 10, 0);
        send(1, 12, 20, 10, 0);
        send(1, 13, 40, 10, 0);
        send(1, 14, 10, 10, 0);
        finish_test();

        start_test("overlap_drop");
        send(0, 20, 1150, 50, 0);
        send(0, 21, 1200, 100, 0);
        finish_test();

        start_test("fin_reopen");
        send(2, 30, 500, 10, 0);
        send(2, 31, 510, 10, 1);
        send(2, 32, 9000, 10, 0);
        finish_test();

        start_test("pool_overflow");
        send(3, 40, 0, 1, 0);
        for (int i = 0; i < `REASM_NODES + 2; i++) begin
            send(3, 41 + i, 2 + i, 1, 0);
        end
        send(3, 60, 1, 1, 0);
        finish_test();

        start_test("hold_pulses");
        hold_en = 1'b1;
        send(1, 70, 70, 10, 0);
        send(1, 71, 60, 10, 0);
        send(1, 72, 80, 10, 0);
        send(1, 73, 50, 10, 0);
        finish_test();
        hold_en = 1'b0;

        // Late extra releases still get caught
        repeat (10) @(negedge clk);
        count_assert_fails();
        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (16 + NUM_TESTS * TEST_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired before the tests completed");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
src/reasm_pkg.sv
src/flow_table.sv
src/ooo_list.sv
src/reasm_ctrl.sv
src/flow_reasm_top.sv
dv/flow_reasm_checker.sv
dv/tb_flow_reasm.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_flow_reasm -Mdir obj_dir
	./obj_dir/Vtb_flow_reasm | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Result: failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || (echo "Result: run ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
